//--- Bender.yml
package:
  name: lcd_panel_ctrl

sources:
  - lcd_pkg.sv
  - lcd_apb_regs.sv
  - lcd_power_seq.sv
  - lcd_sync_gen.sv
  - lcd_pattern_gen.sv
  - lcd_top.sv
  - target: simulation
    files:
      - tb_lcd_checker.sv
      - tb_lcd_top.sv

//--- lcd_apb_regs.sv
`default_nettype none

module lcd_apb_regs (
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [lcd_pkg::APB_AW-1:0] paddr,
    input  logic [lcd_pkg::APB_DW-1:0] pwdata,
    output logic [lcd_pkg::APB_DW-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  logic                       draw_on,
    input  logic                       lcd_rst_n,
    input  logic                       frame_start,
    output lcd_pkg::lcd_ctrl_t         ctrl
);
    import lcd_pkg::*;

    lcd_ctrl_t         ctrl_q;     // ctrl, fg, bg registers
    logic [FCNT_W-1:0] frame_cnt;  // frames drawn
    logic              access;     // apb access phase
    logic              addr_hit;   // mapped address
    logic              bad;        // error condition
    logic              wr_en;
    logic [APB_DW-1:0] rd_data;

    assign access = psel & penable;
    assign pready = 1'b1;  // no wait states

    // address decode and read mux
    always_comb begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (paddr)
            ADDR_CTRL: begin
                rd_data = {{(APB_DW - 3){1'b0}}, ctrl_q.mode, ctrl_q.enable};
            end
            ADDR_FG: begin
                rd_data = {{(APB_DW - 16){1'b0}}, ctrl_q.fg};
            end
            ADDR_BG: begin
                rd_data = {{(APB_DW - 16){1'b0}}, ctrl_q.bg};
            end
            ADDR_STATUS: begin
                rd_data = {{(APB_DW - 17){1'b0}}, lcd_rst_n,  // bit 16
                           frame_cnt,                     // bits 15:8
                           7'd0, draw_on};                // bit 0
            end
            default: begin
                addr_hit = 1'b0;  // unmapped
            end
        endcase
    end

    assign bad     = ~addr_hit | (pwrite & (paddr == ADDR_STATUS));  // status is ro
    assign pslverr = access & bad;
    assign wr_en   = access & pwrite & ~bad;  // error write is dropped
    assign prdata  = (access && !pwrite && !bad) ? rd_data : '0;  // error read -> 0

    // register writes, end of access phase
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            ctrl_q <= '0;
        end else if (wr_en) begin
            case (paddr)
                ADDR_CTRL: begin
                    ctrl_q.enable <= pwdata[0];
                    ctrl_q.mode   <= pattern_e'(pwdata[2:1]);
                end
                ADDR_FG: begin
                    ctrl_q.fg <= rgb565_t'(pwdata[15:0]);
                end
                ADDR_BG: begin
                    ctrl_q.bg <= rgb565_t'(pwdata[15:0]);
                end
                default: begin
                    ctrl_q <= ctrl_q;  // not reachable, bad covers it
                end
            endcase
        end
    end

    // frame counter, only while drawing
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            frame_cnt <= '0;
        end else if (frame_start && draw_on) begin
            frame_cnt <= frame_cnt + 1'b1;  // wraps at 256
        end
    end

    assign ctrl = ctrl_q;

endmodule

`default_nettype wire

//--- lcd_pattern_gen.sv
`default_nettype none

module lcd_pattern_gen (
    input  logic               CLK,
    input  logic               RESET,
    input  lcd_pkg::lcd_pos_t  pos,
    input  lcd_pkg::lcd_ctrl_t ctrl,
    output lcd_pkg::lcd_port_t port
);
    import lcd_pkg::*;

    logic [POS_W-1:0]  bar_div;     // hpos / bar width
    logic [BAR_IW-1:0] bar_idx;     // clamped bar number
    logic              checker_on;  // fg square
    logic              grid_on;     // fg line
    rgb565_t           pix;         // colour for this position
    rgb565_t           pix_de;      // blanked outside de

    assign bar_div = pos.hpos / POS_W'(BAR_W);
    // past the last bar only happens in blanking
    assign bar_idx = (bar_div >= POS_W'(BAR_N)) ? BAR_IW'(BAR_N - 1)
                                                : bar_div[BAR_IW-1:0];

    assign checker_on = pos.hpos[4] ^ pos.vpos[4];  // 16x16 squares
    assign grid_on    = (pos.hpos[3:0] == 4'd0) ||
                        (pos.vpos[3:0] == 4'd0);    // every 16th col/line

    // colour select by mode
    always_comb begin
        case (ctrl.mode)
            PAT_SOLID: begin
                pix = ctrl.bg;
            end
            PAT_BARS: begin
                pix = BAR_COLORS[bar_idx];
            end
            PAT_CHECKER: begin
                pix = checker_on ? ctrl.fg : ctrl.bg;
            end
            PAT_GRID: begin
                pix = grid_on ? ctrl.fg : ctrl.bg;
            end
            default: begin
                pix = ctrl.bg;
            end
        endcase
    end

    assign pix_de = pos.de ? pix : '0;  // black in blanking

    // pin register, one clock after pos
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            port.hsync <= 1'b1;  // inactive
            port.vsync <= 1'b1;
            port.de    <= 1'b0;
            port.rgb   <= '0;
        end else begin
            port.hsync <= pos.hsync;
            port.vsync <= pos.vsync;
            port.de    <= pos.de;
            port.rgb   <= pix_de;
        end
    end

endmodule

`default_nettype wire

//--- lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    // panel timing, 240x320 rgb565
    localparam int H_DISPLAY = 240;  // visible columns
    localparam int H_BACK    = 24;   // left border
    localparam int H_FRONT   = 16;   // right border
    localparam int H_SYNC    = 16;   // hsync width in clocks
    localparam int V_DISPLAY = 320;  // visible lines
    localparam int V_BACK    = 2;    // top border
    localparam int V_FRONT   = 4;    // bottom border
    localparam int V_SYNC    = 4;    // vsync width in lines

    localparam int H_SYNC_START     = H_DISPLAY + H_FRONT;               // 256
    localparam int H_SYNC_END       = H_DISPLAY + H_FRONT + H_SYNC - 1;  // 271
    localparam int H_MAX            = H_DISPLAY + H_BACK + H_FRONT + H_SYNC - 1;  // 295
    localparam int V_SYNC_START     = V_DISPLAY + V_FRONT;               // 324
    localparam int V_SYNC_END       = V_DISPLAY + V_FRONT + V_SYNC - 1;  // 327
    localparam int V_MAX            = V_DISPLAY + V_BACK + V_FRONT + V_SYNC - 1;  // 329
    localparam int DE_START_UP_TIME = H_BACK;  // idle clocks after each line wrap
    localparam int POS_W            = 9;       // hpos/vpos width

    // power-up sequencer
    localparam int RST_HOLD_CYCLES  = 16;  // panel reset low time
    localparam int INIT_WAIT_CYCLES = 64;  // settle time before drawing
    localparam int SEQ_CNT_W        = 7;   // covers both counts
    localparam logic [1:0] SEQ_OFF    = 2'd0;  // panel held off
    localparam logic [1:0] SEQ_HOLD   = 2'd1;  // reset pulse
    localparam logic [1:0] SEQ_SETTLE = 2'd2;  // wait, then draw

    // apb register map
    localparam int APB_AW = 4;
    localparam int APB_DW = 32;
    localparam int FCNT_W = 8;  // frame counter, wraps
    localparam logic [APB_AW-1:0] ADDR_CTRL   = 4'h0;
    localparam logic [APB_AW-1:0] ADDR_FG     = 4'h4;
    localparam logic [APB_AW-1:0] ADDR_BG     = 4'h8;
    localparam logic [APB_AW-1:0] ADDR_STATUS = 4'hC;  // read only

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    localparam int BAR_W  = 30;  // columns per colour bar
    localparam int BAR_N  = 8;
    localparam int BAR_IW = $clog2(BAR_N);
    localparam rgb565_t BAR_COLORS [BAR_N] = '{
        '{5'h1f, 6'h3f, 5'h1f},  // white
        '{5'h1f, 6'h3f, 5'h00},  // yellow
        '{5'h00, 6'h3f, 5'h1f},  // cyan
        '{5'h00, 6'h3f, 5'h00},  // green
        '{5'h1f, 6'h00, 5'h1f},  // magenta
        '{5'h1f, 6'h00, 5'h00},  // red
        '{5'h00, 6'h00, 5'h1f},  // blue
        '{5'h00, 6'h00, 5'h00}   // black
    };

    typedef enum logic [1:0] {
        PAT_SOLID   = 2'd0,
        PAT_BARS    = 2'd1,
        PAT_CHECKER = 2'd2,
        PAT_GRID    = 2'd3
    } pattern_e;

    typedef struct packed {
        logic     enable;
        pattern_e mode;
        rgb565_t  fg;
        rgb565_t  bg;
    } lcd_ctrl_t;

    typedef struct packed {
        logic             hsync;  // active low
        logic             vsync;  // active low
        logic             de;
        logic [POS_W-1:0] hpos;
        logic [POS_W-1:0] vpos;
        logic             frame_start;
    } lcd_pos_t;

    typedef struct packed {
        logic    hsync;
        logic    vsync;
        logic    de;
        rgb565_t rgb;
    } lcd_port_t;

endpackage

`default_nettype wire

//--- lcd_power_seq.sv
`default_nettype none

module lcd_power_seq (
    input  logic CLK,
    input  logic RESET,
    input  logic enable,
    output logic draw_on,
    output logic lcd_rst_n
);
    import lcd_pkg::*;

    logic [1:0]           state;    // off / hold / settle
    logic [SEQ_CNT_W-1:0] cnt;      // shared cycle counter
    logic                 draw_q;
    logic                 rst_n_q;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            state   <= SEQ_OFF;
            cnt     <= '0;
            draw_q  <= 1'b0;
            rst_n_q <= 1'b0;  // panel in reset
        end else if (!enable) begin
            // withdrawn enable drops everything next clock
            state   <= SEQ_OFF;
            cnt     <= '0;
            draw_q  <= 1'b0;
            rst_n_q <= 1'b0;
        end else begin
            case (state)
                SEQ_OFF: begin
                    state <= SEQ_HOLD;          // start reset pulse
                    cnt   <= SEQ_CNT_W'(1);     // off clock is the first hold clock
                end
                SEQ_HOLD: begin
                    if (cnt == SEQ_CNT_W'(RST_HOLD_CYCLES - 1)) begin
                        state   <= SEQ_SETTLE;
                        cnt     <= '0;
                        rst_n_q <= 1'b1;  // release panel reset
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                SEQ_SETTLE: begin
                    if (cnt == SEQ_CNT_W'(INIT_WAIT_CYCLES - 1)) begin
                        draw_q <= 1'b1;  // hold here while enabled
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= SEQ_OFF;  // illegal code
                end
            endcase
        end
    end

    assign draw_on   = draw_q;
    assign lcd_rst_n = rst_n_q;

endmodule

`default_nettype wire

//--- lcd_sync_gen.sv
`default_nettype none

module lcd_sync_gen (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              draw_on,
    output lcd_pkg::lcd_pos_t pos
);
    import lcd_pkg::*;

    logic [POS_W-1:0] hpos;         // column counter
    logic [POS_W-1:0] vpos;         // line counter
    logic [POS_W-1:0] de_start_up;  // idle clocks since line wrap
    logic             hmax;
    logic             vmax;
    logic             su_done;      // start-up delay elapsed

    assign hmax    = (hpos == POS_W'(H_MAX));
    assign vmax    = (vpos == POS_W'(V_MAX));
    assign su_done = (de_start_up == POS_W'(DE_START_UP_TIME));

    // horizontal counter, held until start-up done
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            hpos <= '0;
        end else if (hmax) begin
            hpos <= '0;
        end else if (su_done && draw_on) begin
            hpos <= hpos + 1'b1;
        end
    end

    // vertical counter, steps on line wrap
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            vpos <= '0;
        end else if (hmax) begin
            if (vmax) begin
                vpos <= '0;
            end else if (draw_on) begin
                vpos <= vpos + 1'b1;
            end
        end
    end

    // start-up delay, restarted every line
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            de_start_up <= '0;
        end else if (hmax) begin
            de_start_up <= '0;
        end else if (!su_done && draw_on) begin
            de_start_up <= de_start_up + 1'b1;
        end
    end

    // sync, de and frame pulse straight from the counters
    always_comb begin
        pos.hsync = ~((hpos >= POS_W'(H_SYNC_START)) &&
                      (hpos <= POS_W'(H_SYNC_END)));  // low in window
        pos.vsync = ~((vpos >= POS_W'(V_SYNC_START)) &&
                      (vpos <= POS_W'(V_SYNC_END)));
        pos.de    = (hpos < POS_W'(H_DISPLAY)) && (vpos < POS_W'(V_DISPLAY)) &&
                    draw_on && su_done;
        pos.hpos  = hpos;
        pos.vpos  = vpos;
        pos.frame_start = hmax & vmax;  // last pixel of the frame
    end

endmodule

`default_nettype wire

//--- lcd_top.sv
`default_nettype none

module lcd_top (
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [lcd_pkg::APB_AW-1:0] paddr,
    input  logic [lcd_pkg::APB_DW-1:0] pwdata,
    output logic [lcd_pkg::APB_DW-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       lcd_rst_n,
    output lcd_pkg::lcd_port_t         port
);
    import lcd_pkg::*;

    lcd_ctrl_t ctrl;     // register contents
    logic      draw_on;  // panel ready for pixels
    lcd_pos_t  pos;      // timing and position

    lcd_apb_regs u_regs (
        .CLK         (CLK),
        .RESET       (RESET),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .draw_on     (draw_on),
        .lcd_rst_n   (lcd_rst_n),
        .frame_start (pos.frame_start),
        .ctrl        (ctrl)
    );

    lcd_power_seq u_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .enable    (ctrl.enable),
        .draw_on   (draw_on),
        .lcd_rst_n (lcd_rst_n)
    );

    lcd_sync_gen u_sync (
        .CLK     (CLK),
        .RESET   (RESET),
        .draw_on (draw_on),
        .pos     (pos)
    );

    lcd_pattern_gen u_pat (
        .CLK   (CLK),
        .RESET (RESET),
        .pos   (pos),
        .ctrl  (ctrl),
        .port  (port)
    );

endmodule

`default_nettype wire

//--- tb_lcd_checker.sv
`default_nettype none

module tb_lcd_checker (
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [lcd_pkg::APB_AW-1:0] paddr,
    input  logic [lcd_pkg::APB_DW-1:0] pwdata,
    input  logic [lcd_pkg::APB_DW-1:0] prdata,
    input  logic                       pready,
    input  logic                       pslverr,
    input  logic                       lcd_rst_n,
    input  lcd_pkg::lcd_port_t         pins,
    input  lcd_pkg::lcd_ctrl_t         exp,      // expected register contents
    output int                         errors,
    output int                         checks
);
    import lcd_pkg::*;

    // pins are seen a clock late
    localparam int RST_SEEN  = RST_HOLD_CYCLES + 1;
    localparam int DRAW_SEEN = RST_SEEN + INIT_WAIT_CYCLES;
    localparam int LINE_CLKS = H_MAX + 1 + DE_START_UP_TIME;  // start-up idle every line
    localparam int SAT       = 1000000;

    logic en_sh;        // enable as seen on the bus
    int   pu_cnt;       // clocks since enable write
    int   dis_age;      // clocks since disable write
    logic pv_hs, pv_vs, pv_de;
    logic synced;       // column/line known
    logic hs_seen, hs_low_ok, vs_valid, frame_valid, vs_pending;
    int   col, line;    // rebuilt from de runs and vsync
    int   hs_cnt, hs_low, vs_hs;
    int   frames;       // frames drawn as status counts them

    task automatic expect_val(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got 0x%0h expected 0x%0h",
                     $time, name, got, want);
        end
    endtask

    function automatic logic [15:0] bar_color(input int idx);
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
        r = idx[1] ? 5'h00 : 5'h1f;  // white yellow .. magenta red
        g = idx[2] ? 6'h00 : 6'h3f;  // first four bars
        b = idx[0] ? 5'h00 : 5'h1f;  // every other bar
        return {r, g, b};
    endfunction

    function automatic logic [15:0] pixel_model(input lcd_ctrl_t c, input int x,
                                                input int y);
        logic [15:0] fg;
        logic [15:0] bg;
        fg = c.fg;
        bg = c.bg;
        case (c.mode)
            PAT_SOLID:   return bg;
            PAT_BARS:    return bar_color(x / 30);
            PAT_CHECKER: return (x[4] != y[4]) ? fg : bg;
            default:     return ((x % 16 == 0) || (y % 16 == 0)) ? fg : bg;
        endcase
    endfunction

    always @(posedge CLK) begin : sample
        logic        hs_fall, hs_rise, vs_fall, vs_rise, de_rise, de_fall;
        logic        err_exp;
        logic [31:0] want_rd;
        hs_fall = pv_hs & ~pins.hsync;
        hs_rise = ~pv_hs & pins.hsync;
        vs_fall = pv_vs & ~pins.vsync;
        vs_rise = ~pv_vs & pins.vsync;
        de_rise = ~pv_de & pins.de;
        de_fall = pv_de & ~pins.de;
        if (!RESET) begin
            en_sh       = 0;
            pu_cnt      = SAT;
            dis_age     = SAT;
            synced      = 0;
            hs_seen     = 0;
            hs_low_ok   = 0;
            vs_valid    = 0;
            frame_valid = 0;
            vs_pending  = 0;
            col         = 0;
            line        = 0;
            hs_cnt      = 0;
            hs_low      = 0;
            vs_hs       = 0;
            frames      = 0;
            pv_hs       = 1;
            pv_vs       = 1;
            pv_de       = 0;
            errors      = 0;
            checks      = 0;
        end else begin
            if (pu_cnt < SAT) pu_cnt++;
            if (dis_age < SAT) dis_age++;
            hs_cnt++;
            // apb access phase
            if (psel && penable) begin
                err_exp = !(paddr == ADDR_CTRL || paddr == ADDR_FG ||
                            paddr == ADDR_BG || paddr == ADDR_STATUS) ||
                          (pwrite && paddr == ADDR_STATUS);
                expect_val("pready", pready, 1);
                expect_val("pslverr", pslverr, err_exp);
                if (!pwrite) begin
                    want_rd = '0;
                    if (!err_exp) begin
                        case (paddr)
                            ADDR_CTRL:   want_rd = {29'd0, exp.mode, exp.enable};
                            ADDR_FG:     want_rd = {16'd0, exp.fg};
                            ADDR_BG:     want_rd = {16'd0, exp.bg};
                            default:     want_rd = {15'd0, en_sh && pu_cnt >= RST_SEEN,
                                                    frames[7:0], 7'd0,
                                                    en_sh && pu_cnt >= DRAW_SEEN};
                        endcase
                    end
                    expect_val("prdata", prdata, want_rd);
                end
            end
            // power-up and shutdown
            if (en_sh && pu_cnt >= 1) begin
                expect_val("lcd_rst_n", lcd_rst_n, pu_cnt >= RST_SEEN);
            end else if (!en_sh && dis_age >= 2) begin
                expect_val("lcd_rst_n", lcd_rst_n, 0);
            end
            if ((en_sh && pu_cnt <= DRAW_SEEN) || (!en_sh && dis_age >= 3)) begin
                expect_val("de while not drawing", pins.de, 0);
            end
            if (!pins.de) begin
                expect_val("rgb outside de", pins.rgb, 0);
            end
            if (!en_sh) begin
                synced      = 0;
                hs_seen     = 0;
                hs_low_ok   = 0;
                vs_valid    = 0;
                frame_valid = 0;
            end
            // vertical timing
            if (vs_fall) begin
                vs_valid = synced;
                vs_hs    = 0;
            end
            if (vs_rise) begin
                if (vs_valid) expect_val("vsync low lines", vs_hs, V_SYNC);
                if (frame_valid) expect_val("de lines per frame", line, V_DISPLAY);
                synced      = en_sh;
                frame_valid = synced;
                line        = 0;
                vs_pending  = 1;
            end
            // horizontal timing
            if (hs_fall) begin
                if (synced && hs_seen) expect_val("hsync period", hs_cnt, LINE_CLKS);
                hs_seen   = synced;
                hs_cnt    = 0;
                hs_low    = 0;
                hs_low_ok = synced;
                if (!pins.vsync) vs_hs++;
            end
            if (!pins.hsync) hs_low++;
            if (hs_rise && hs_low_ok) expect_val("hsync low clocks", hs_low, H_SYNC);
            // pixels
            if (de_rise) begin
                col = 0;
                if (vs_pending) begin
                    frames++;  // frame ended before this first line
                    vs_pending = 0;
                end
            end
            if (pins.de) begin
                if (synced) expect_val("rgb", pins.rgb, pixel_model(exp, col, line));
                col++;
            end
            if (de_fall) begin
                if (synced) expect_val("de clocks per line", col, H_DISPLAY);
                line++;
            end
            // bus snoop for enable edges
            if (psel && penable && pwrite && paddr == ADDR_CTRL) begin
                if (pwdata[0] && !en_sh) pu_cnt = 0;
                if (!pwdata[0] && en_sh) dis_age = 0;
                en_sh = pwdata[0];
            end
            pv_hs = pins.hsync;
            pv_vs = pins.vsync;
            pv_de = pins.de;
        end
    end

endmodule

`default_nettype wire

//--- tb_lcd_top.sv
`default_nettype none

module tb_lcd_top;
    import lcd_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int ROWS         = 6;
    localparam int LINE_CLOCKS  = H_MAX + 1 + DE_START_UP_TIME;
    localparam int FRAME_CLOCKS = LINE_CLOCKS * (V_MAX + 1);
    localparam int POLL_LIMIT   = 200;  // status reads while powering up

    typedef struct packed {
        pattern_e    mode;
        logic [15:0] fg;
        logic [15:0] bg;
        logic [3:0]  frames;  // frames to run
        logic        rnd;     // pick colours at random
    } row_t;

    logic              CLK;
    logic              RESET;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              lcd_rst_n;
    lcd_port_t         port;
    lcd_ctrl_t         exp_ctrl;    // to the checker
    int                chk_errors;
    int                chk_checks;
    int                drv_errors;
    row_t              rows [ROWS];

    lcd_top dut0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .lcd_rst_n (lcd_rst_n),
        .port      (port)
    );

    tb_lcd_checker checker0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .lcd_rst_n (lcd_rst_n),
        .pins      (port),
        .exp       (exp_ctrl),
        .errors    (chk_errors),
        .checks    (chk_checks)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // setup then access phase without wait states
    task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
                              input logic [31:0] data, output logic [31:0] rd);
        @(posedge CLK);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge CLK);
        #1;
        penable = 1'b1;
        #1;
        rd = prdata;
        @(posedge CLK);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
        logic [31:0] dummy;
        apb_access(1'b1, addr, data, dummy);
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] rd);
        apb_access(1'b0, addr, 32'd0, rd);
    endtask

    // sel 0 waits for vsync, 1 for de
    task automatic wait_pin_rise(input int sel, input string what);
        logic prev;
        logic cur;
        logic seen;
        int   n;
        prev = (sel == 0) ? port.vsync : port.de;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < 2 * FRAME_CLOCKS) begin
            @(posedge CLK);
            cur  = (sel == 0) ? port.vsync : port.de;
            seen = !prev && cur;
            prev = cur;
            n++;
        end
        if (!seen) begin
            drv_errors++;
            $display("t=%0t no rising edge of %s within two frame times", $time, what);
        end
    endtask

    task automatic wait_draw_on();
        logic [31:0] rd;
        int          n;
        rd = '0;
        n  = 0;
        while (!rd[0] && n < POLL_LIMIT) begin
            apb_read(ADDR_STATUS, rd);
            n++;
        end
        if (!rd[0]) begin
            drv_errors++;
            $display("t=%0t draw_on never read back as 1 after enable", $time);
        end
    endtask

    initial begin : watchdog
        longint limit;
        int     total;
        #1;
        total = 0;
        for (int i = 0; i < ROWS; i++) total += rows[i].frames;
        // alignment and shutdown frame per row on top of the drawn frames
        limit = 2 * longint'(total + 2 * ROWS) * FRAME_CLOCKS * CLK_PERIOD + 10000;
        #(limit);
        $display("watchdog: run did not finish within %0d time units", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : driver
        logic [31:0] rd;
        void'($urandom(16694));
        rows[0] = '{PAT_SOLID,   16'hf800, 16'h07e0, 4'd1, 1'b0};
        rows[1] = '{PAT_BARS,    16'h0000, 16'h0000, 4'd1, 1'b0};
        rows[2] = '{PAT_CHECKER, 16'h0000, 16'h0000, 4'd2, 1'b1};
        rows[3] = '{PAT_GRID,    16'h0000, 16'h0000, 4'd1, 1'b1};
        rows[4] = '{PAT_SOLID,   16'h0000, 16'h0000, 4'd1, 1'b1};
        rows[5] = '{PAT_CHECKER, 16'hffff, 16'h001f, 4'd1, 1'b0};
        drv_errors = 0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        exp_ctrl   = '0;
        RESET      = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        RESET = 1'b1;

        // register access while the panel is still off
        exp_ctrl.fg   = rgb565_t'(16'h1234);
        exp_ctrl.bg   = rgb565_t'(16'habcd);
        exp_ctrl.mode = PAT_CHECKER;
        apb_write(ADDR_FG, 32'hdead_1234);  // upper half ignored
        apb_write(ADDR_BG, 32'h0000_abcd);
        apb_write(ADDR_CTRL, 32'h4);
        apb_read(ADDR_FG, rd);
        apb_read(ADDR_BG, rd);
        apb_read(ADDR_CTRL, rd);
        apb_write(ADDR_STATUS, 32'hffff_ffff);  // read-only
        apb_write(4'h6, 32'h5555);              // unmapped
        apb_read(4'h2, rd);
        apb_read(ADDR_FG, rd);
        apb_read(ADDR_BG, rd);
        apb_read(ADDR_CTRL, rd);
        apb_read(ADDR_STATUS, rd);

        for (int i = 0; i < ROWS; i++) begin
            if (rows[i].rnd) begin
                rows[i].fg = 16'($urandom());
                rows[i].bg = 16'($urandom());
            end
            exp_ctrl.fg   = rgb565_t'(rows[i].fg);
            exp_ctrl.bg   = rgb565_t'(rows[i].bg);
            apb_write(ADDR_FG, {16'd0, rows[i].fg});
            apb_write(ADDR_BG, {16'd0, rows[i].bg});
            exp_ctrl.mode   = rows[i].mode;
            exp_ctrl.enable = 1'b1;
            apb_write(ADDR_CTRL, {29'd0, rows[i].mode, 1'b1});
            wait_draw_on();
            for (int f = 0; f < rows[i].frames; f++) begin
                wait_pin_rise(0, "vsync");
                wait_pin_rise(1, "de");  // first line of the next frame
            end
            apb_read(ADDR_STATUS, rd);
            apb_read(ADDR_CTRL, rd);
            exp_ctrl.enable = 1'b0;
            apb_write(ADDR_CTRL, {29'd0, rows[i].mode, 1'b0});
            apb_read(ADDR_STATUS, rd);
            repeat (FRAME_CLOCKS) @(posedge CLK);  // de must stay low
        end

        repeat (4) @(posedge CLK);
        $display("errors: checker %0d of %0d checks, driver %0d",
                 chk_errors, chk_checks, drv_errors);
        if (chk_errors == 0 && drv_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
lcd_pkg.sv
lcd_apb_regs.sv
lcd_power_seq.sv
lcd_sync_gen.sv
lcd_pattern_gen.sv
lcd_top.sv
tb_lcd_checker.sv
tb_lcd_top.sv
